// File: src/noc_pkg.sv
// Shared definitions for the mesh router
// Port indices, coordinate and flit widths, vector typedefs
// Configuration port types and the output arbiter state encoding

package noc_pkg;

  // Router ports
  localparam int unsigned NumPorts     = 5;
  localparam int unsigned PortIdxWidth = $clog2(NumPorts);
  localparam int unsigned PortLocal    = 0;
  localparam int unsigned PortNorth    = 1;
  localparam int unsigned PortEast     = 2;
  localparam int unsigned PortSouth    = 3;
  localparam int unsigned PortWest     = 4;

  // Node coordinate, x in the low half and y in the high half
  localparam int unsigned CoordWidth  = 3;
  localparam int unsigned NodeIdWidth = 2 * CoordWidth;

  // Header is destination then source, in the top bits of a flit
  localparam int unsigned HdrWidth           = 2 * NodeIdWidth;
  localparam int unsigned NarrowPayloadWidth = 28;
  localparam int unsigned WidePayloadWidth   = 60;
  localparam int unsigned NarrowFlitWidth    = HdrWidth + NarrowPayloadWidth;
  localparam int unsigned WideFlitWidth      = HdrWidth + WidePayloadWidth;

  localparam int unsigned InFifoDepth = 2;

  typedef logic [CoordWidth-1:0]      coord_t;
  typedef logic [NodeIdWidth-1:0]     node_id_t;
  typedef logic [NarrowFlitWidth-1:0] narrow_flit_t;
  typedef logic [WideFlitWidth-1:0]   wide_flit_t;
  typedef logic [NumPorts-1:0]        port_mask_t;
  typedef logic [PortIdxWidth-1:0]    port_idx_t;

  // Configuration register map
  typedef logic [0:0] cfg_addr_t;
  typedef logic [7:0] cfg_data_t;

  localparam cfg_addr_t CfgAddrCoord  = 1'b0;
  localparam cfg_addr_t CfgAddrEnable = 1'b1;

  // Per-output arbiter, locked while the granted flit waits for ready
  typedef enum logic {
    ArbIdle,
    ArbLocked
  } arb_state_e;

endpackage

// File: src/noc_input_fifo.sv
// Two-entry input buffer with valid/ready on both sides
// Accepts only while enabled, drains regardless of enable

`timescale 1ns/1ns

module noc_input_fifo #(
  parameter int unsigned Width = 40
) (
  input  logic             clk_i,
  input  logic             arst_n_i,
  input  logic             en_i,
  input  logic             in_valid_i,
  output logic             in_ready_o,
  input  logic [Width-1:0] in_data_i,
  output logic             out_valid_o,
  input  logic             out_ready_i,
  output logic [Width-1:0] out_data_o
);

  localparam int unsigned PtrWidth = $clog2(noc_pkg::InFifoDepth);
  localparam int unsigned CntWidth = $clog2(noc_pkg::InFifoDepth + 1);

  logic [Width-1:0]    mem_q [noc_pkg::InFifoDepth];
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                push;
  logic                pop;

  assign in_ready_o  = en_i && (count_q < CntWidth'(noc_pkg::InFifoDepth));
  assign out_valid_o = (count_q != '0);
  assign out_data_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= wr_ptr_q + PtrWidth'(1);
      if (pop) rd_ptr_q <= rd_ptr_q + PtrWidth'(1);
      // Simultaneous push and pop leave the count unchanged
      if (push && !pop) count_q <= count_q + CntWidth'(1);
      else if (pop && !push) count_q <= count_q - CntWidth'(1);
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (push) mem_q[wr_ptr_q] <= in_data_i;
  end

endmodule

// File: src/noc_xy_route.sv
// XY output-port selection for one head flit
// X is corrected first, then Y; own coordinate leaves on Local

`timescale 1ns/1ns

module noc_xy_route (
  input  noc_pkg::node_id_t   dst_i,
  input  noc_pkg::node_id_t   node_id_i,
  output noc_pkg::port_mask_t port_o
);

  noc_pkg::coord_t dst_x;
  noc_pkg::coord_t dst_y;
  noc_pkg::coord_t own_x;
  noc_pkg::coord_t own_y;

  assign dst_x = dst_i[noc_pkg::CoordWidth-1:0];
  assign dst_y = dst_i[noc_pkg::NodeIdWidth-1:noc_pkg::CoordWidth];
  assign own_x = node_id_i[noc_pkg::CoordWidth-1:0];
  assign own_y = node_id_i[noc_pkg::NodeIdWidth-1:noc_pkg::CoordWidth];

  always_comb begin
    port_o = '0;
    if (dst_x > own_x) begin
      port_o[noc_pkg::PortEast] = 1'b1;
    end else if (dst_x < own_x) begin
      port_o[noc_pkg::PortWest] = 1'b1;
    end else if (dst_y > own_y) begin
      port_o[noc_pkg::PortNorth] = 1'b1;
    end else if (dst_y < own_y) begin
      port_o[noc_pkg::PortSouth] = 1'b1;
    end else begin
      port_o[noc_pkg::PortLocal] = 1'b1;
    end
  end

endmodule

// File: src/noc_plane_router.sv
// One routing plane of the mesh router
// Input buffers, XY route selection per buffer head,
// round-robin output arbiters with lock, and the crossbar

`timescale 1ns/1ns

module noc_plane_router #(
  parameter int unsigned FlitWidth = 40
) (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  noc_pkg::node_id_t                             node_id_i,
  input  logic                                          en_i,
  input  logic [noc_pkg::NumPorts-1:0]                  in_valid_i,
  output logic [noc_pkg::NumPorts-1:0]                  in_ready_o,
  input  logic [noc_pkg::NumPorts-1:0][FlitWidth-1:0]   in_data_i,
  output logic [noc_pkg::NumPorts-1:0]                  out_valid_o,
  input  logic [noc_pkg::NumPorts-1:0]                  out_ready_i,
  output logic [noc_pkg::NumPorts-1:0][FlitWidth-1:0]   out_data_o
);

  localparam int unsigned NumPorts = noc_pkg::NumPorts;

  logic [NumPorts-1:0]                head_valid;
  logic [NumPorts-1:0]                head_pop;
  logic [NumPorts-1:0][FlitWidth-1:0] head_data;
  noc_pkg::port_mask_t                route_mask [NumPorts];
  // Request matrix, indexed by output then input
  logic [NumPorts-1:0][NumPorts-1:0]  req_mat;
  noc_pkg::port_idx_t                 grant_idx [NumPorts];

  for (genvar i = 0; i < NumPorts; i++) begin : gen_input
    noc_input_fifo #(
      .Width ( FlitWidth )
    ) i_in_fifo (
      .clk_i,
      .arst_n_i,
      .en_i,
      .in_valid_i  ( in_valid_i[i]  ),
      .in_ready_o  ( in_ready_o[i]  ),
      .in_data_i   ( in_data_i[i]   ),
      .out_valid_o ( head_valid[i]  ),
      .out_ready_i ( head_pop[i]    ),
      .out_data_o  ( head_data[i]   )
    );

    // Destination id sits in the topmost header bits
    noc_xy_route i_xy_route (
      .dst_i     ( head_data[i][FlitWidth-1 -: noc_pkg::NodeIdWidth] ),
      .node_id_i ( node_id_i     ),
      .port_o    ( route_mask[i] )
    );

    for (genvar o = 0; o < NumPorts; o++) begin : gen_req
      assign req_mat[o][i] = head_valid[i] && route_mask[i][o];
    end
  end

  for (genvar o = 0; o < NumPorts; o++) begin : gen_output
    noc_pkg::arb_state_e state_q;
    noc_pkg::port_idx_t  lock_q;
    noc_pkg::port_idx_t  prio_q;
    noc_pkg::port_idx_t  rr_idx;

    // First requester at or after the priority pointer
    always_comb begin
      int unsigned cand;
      logic        found;
      found  = 1'b0;
      rr_idx = '0;
      for (int k = 0; k < NumPorts; k++) begin
        cand = (int'(prio_q) + k) % NumPorts;
        if (!found && req_mat[o][cand]) begin
          found  = 1'b1;
          rr_idx = noc_pkg::port_idx_t'(cand);
        end
      end
    end

    assign grant_idx[o]  = (state_q == noc_pkg::ArbLocked) ? lock_q : rr_idx;
    assign out_valid_o[o] = req_mat[o][grant_idx[o]];
    assign out_data_o[o]  = head_data[grant_idx[o]];

    always_ff @(posedge clk_i or negedge arst_n_i) begin
      if (!arst_n_i) begin
        state_q <= noc_pkg::ArbIdle;
        lock_q  <= '0;
        prio_q  <= '0;
      end else if (out_valid_o[o]) begin
        if (out_ready_i[o]) begin
          state_q <= noc_pkg::ArbIdle;
          // Move priority past the winner
          prio_q  <= (grant_idx[o] == noc_pkg::port_idx_t'(NumPorts - 1)) ?
                     '0 : grant_idx[o] + noc_pkg::port_idx_t'(1);
        end else begin
          state_q <= noc_pkg::ArbLocked;
          lock_q  <= grant_idx[o];
        end
      end
    end
  end

  // A head leaves its buffer when the output it won accepts
  always_comb begin
    head_pop = '0;
    for (int o = 0; o < NumPorts; o++) begin
      if (out_valid_o[o] && out_ready_i[o]) head_pop[grant_idx[o]] = 1'b1;
    end
  end

endmodule

// File: src/noc_route_cfg.sv
// Configuration registers for node coordinate and router enable
// Written through a four-phase req/ack port

`timescale 1ns/1ns

module noc_route_cfg (
  input  logic               clk_i,
  input  logic               arst_n_i,
  input  logic               cfg_req_i,
  input  noc_pkg::cfg_addr_t cfg_addr_i,
  input  noc_pkg::cfg_data_t cfg_wdata_i,
  output logic               cfg_ack_o,
  output noc_pkg::node_id_t  node_id_o,
  output logic               router_en_o
);

  logic write_en;

  // Ack follows req by one cycle, write happens as ack rises
  assign write_en = cfg_req_i && !cfg_ack_o;

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      cfg_ack_o <= 1'b0;
    end else begin
      cfg_ack_o <= cfg_req_i;
    end
  end

  always_ff @(posedge clk_i or negedge arst_n_i) begin
    if (!arst_n_i) begin
      node_id_o   <= '0;
      router_en_o <= 1'b0;
    end else if (write_en) begin
      if (cfg_addr_i == noc_pkg::CfgAddrCoord) begin
        // Data bits [2:0] are x, [5:3] are y
        node_id_o <= cfg_wdata_i[noc_pkg::NodeIdWidth-1:0];
      end else if (cfg_addr_i == noc_pkg::CfgAddrEnable) begin
        router_en_o <= cfg_wdata_i[0];
      end
    end
  end

endmodule

// File: src/noc_nw_router.sv
// Top level of the mesh router node
// Configuration block plus narrow request, narrow response and wide planes

`timescale 1ns/1ns

module noc_nw_router (
  input  logic                                            clk_i,
  input  logic                                            arst_n_i,
  input  logic                                            cfg_req_i,
  input  noc_pkg::cfg_addr_t                              cfg_addr_i,
  input  noc_pkg::cfg_data_t                              cfg_wdata_i,
  output logic                                            cfg_ack_o,
  // Narrow request plane
  input  logic [noc_pkg::NumPorts-1:0]                    req_in_valid_i,
  output logic [noc_pkg::NumPorts-1:0]                    req_in_ready_o,
  input  noc_pkg::narrow_flit_t [noc_pkg::NumPorts-1:0]   req_in_data_i,
  output logic [noc_pkg::NumPorts-1:0]                    req_out_valid_o,
  input  logic [noc_pkg::NumPorts-1:0]                    req_out_ready_i,
  output noc_pkg::narrow_flit_t [noc_pkg::NumPorts-1:0]   req_out_data_o,
  // Narrow response plane
  input  logic [noc_pkg::NumPorts-1:0]                    rsp_in_valid_i,
  output logic [noc_pkg::NumPorts-1:0]                    rsp_in_ready_o,
  input  noc_pkg::narrow_flit_t [noc_pkg::NumPorts-1:0]   rsp_in_data_i,
  output logic [noc_pkg::NumPorts-1:0]                    rsp_out_valid_o,
  input  logic [noc_pkg::NumPorts-1:0]                    rsp_out_ready_i,
  output noc_pkg::narrow_flit_t [noc_pkg::NumPorts-1:0]   rsp_out_data_o,
  // Wide plane
  input  logic [noc_pkg::NumPorts-1:0]                    wide_in_valid_i,
  output logic [noc_pkg::NumPorts-1:0]                    wide_in_ready_o,
  input  noc_pkg::wide_flit_t [noc_pkg::NumPorts-1:0]     wide_in_data_i,
  output logic [noc_pkg::NumPorts-1:0]                    wide_out_valid_o,
  input  logic [noc_pkg::NumPorts-1:0]                    wide_out_ready_i,
  output noc_pkg::wide_flit_t [noc_pkg::NumPorts-1:0]     wide_out_data_o
);

  noc_pkg::node_id_t node_id;
  logic              router_en;

  noc_route_cfg i_route_cfg (
    .clk_i,
    .arst_n_i,
    .cfg_req_i,
    .cfg_addr_i,
    .cfg_wdata_i,
    .cfg_ack_o,
    .node_id_o   ( node_id   ),
    .router_en_o ( router_en )
  );

  noc_plane_router #(
    .FlitWidth ( noc_pkg::NarrowFlitWidth )
  ) i_req_plane (
    .clk_i, .arst_n_i,
    .node_id_i   ( node_id         ),
    .en_i        ( router_en       ),
    .in_valid_i  ( req_in_valid_i  ),
    .in_ready_o  ( req_in_ready_o  ),
    .in_data_i   ( req_in_data_i   ),
    .out_valid_o ( req_out_valid_o ),
    .out_ready_i ( req_out_ready_i ),
    .out_data_o  ( req_out_data_o  )
  );

  noc_plane_router #(
    .FlitWidth ( noc_pkg::NarrowFlitWidth )
  ) i_rsp_plane (
    .clk_i, .arst_n_i,
    .node_id_i   ( node_id         ),
    .en_i        ( router_en       ),
    .in_valid_i  ( rsp_in_valid_i  ),
    .in_ready_o  ( rsp_in_ready_o  ),
    .in_data_i   ( rsp_in_data_i   ),
    .out_valid_o ( rsp_out_valid_o ),
    .out_ready_i ( rsp_out_ready_i ),
    .out_data_o  ( rsp_out_data_o  )
  );

  noc_plane_router #(
    .FlitWidth ( noc_pkg::WideFlitWidth )
  ) i_wide_plane (
    .clk_i, .arst_n_i,
    .node_id_i   ( node_id          ),
    .en_i        ( router_en        ),
    .in_valid_i  ( wide_in_valid_i  ),
    .in_ready_o  ( wide_in_ready_o  ),
    .in_data_i   ( wide_in_data_i   ),
    .out_valid_o ( wide_out_valid_o ),
    .out_ready_i ( wide_out_ready_i ),
    .out_data_o  ( wide_out_data_o  )
  );

endmodule

// File: dv/noc_nw_router_checker.sv
// Checker for the mesh router testbench
// Reference XY routing, expected queues per plane, input and output,
// output hold check and error counting

`timescale 1ns/1ns

module noc_nw_router_checker (
  input  logic                                          clk_i,
  input  logic                                          arst_n_i,
  input  logic                                          cfg_req_i,
  input  noc_pkg::cfg_addr_t                            cfg_addr_i,
  input  noc_pkg::cfg_data_t                            cfg_wdata_i,
  input  logic                                          cfg_ack_i,
  input  logic [4:0]                                    req_in_valid_i,
  input  logic [4:0]                                    req_in_ready_i,
  input  noc_pkg::narrow_flit_t [4:0]                   req_in_data_i,
  input  logic [4:0]                                    req_out_valid_i,
  input  logic [4:0]                                    req_out_ready_i,
  input  noc_pkg::narrow_flit_t [4:0]                   req_out_data_i,
  input  logic [4:0]                                    rsp_in_valid_i,
  input  logic [4:0]                                    rsp_in_ready_i,
  input  noc_pkg::narrow_flit_t [4:0]                   rsp_in_data_i,
  input  logic [4:0]                                    rsp_out_valid_i,
  input  logic [4:0]                                    rsp_out_ready_i,
  input  noc_pkg::narrow_flit_t [4:0]                   rsp_out_data_i,
  input  logic [4:0]                                    wide_in_valid_i,
  input  logic [4:0]                                    wide_in_ready_i,
  input  noc_pkg::wide_flit_t [4:0]                     wide_in_data_i,
  input  logic [4:0]                                    wide_out_valid_i,
  input  logic [4:0]                                    wide_out_ready_i,
  input  noc_pkg::wide_flit_t [4:0]                     wide_out_data_i,
  output int                                            err_count_o,
  output int                                            checked_o,
  output int                                            pending_o [3]
);

  logic [4:0]  iv [3];
  logic [4:0]  ir [3];
  logic [4:0]  ov [3];
  logic [4:0]  orr [3];
  logic [71:0] id [3][5];
  logic [71:0] od [3][5];
  logic [71:0] exp_q [3][5][5][$];
  logic [4:0]  held_q [3];
  logic [71:0] held_d [3][5];
  logic [5:0]  node_q;
  logic        en_q;
  int          err_count = 0;
  int          checked = 0;
  int          pending [3];

  assign err_count_o = err_count;
  assign checked_o   = checked;
  assign pending_o   = pending;

  // Planes gathered into arrays with narrow flits zero-extended
  always_comb begin
    iv[0]  = req_in_valid_i;
    iv[1]  = rsp_in_valid_i;
    iv[2]  = wide_in_valid_i;
    ir[0]  = req_in_ready_i;
    ir[1]  = rsp_in_ready_i;
    ir[2]  = wide_in_ready_i;
    ov[0]  = req_out_valid_i;
    ov[1]  = rsp_out_valid_i;
    ov[2]  = wide_out_valid_i;
    orr[0] = req_out_ready_i;
    orr[1] = rsp_out_ready_i;
    orr[2] = wide_out_ready_i;
    for (int k = 0; k < 5; k++) begin
      id[0][k] = {32'd0, req_in_data_i[k]};
      id[1][k] = {32'd0, rsp_in_data_i[k]};
      id[2][k] = wide_in_data_i[k];
      od[0][k] = {32'd0, req_out_data_i[k]};
      od[1][k] = {32'd0, rsp_out_data_i[k]};
      od[2][k] = wide_out_data_i[k];
    end
  end

  // Header field at a given offset below the flit top
  function automatic logic [5:0] hdr_field(input int p, input logic [71:0] f, input int off);
    int w;
    w = (p == 2) ? 72 : 40;
    return 6'(f >> (w - off));
  endfunction

  // Expected output port by dimension-ordered XY routing
  function automatic int expected_port(input logic [5:0] dst, input logic [5:0] node);
    if (dst[2:0] > node[2:0]) return noc_pkg::PortEast;
    if (dst[2:0] < node[2:0]) return noc_pkg::PortWest;
    if (dst[5:3] > node[5:3]) return noc_pkg::PortNorth;
    if (dst[5:3] < node[5:3]) return noc_pkg::PortSouth;
    return noc_pkg::PortLocal;
  endfunction

  initial begin
    for (int p = 0; p < 3; p++) pending[p] = 0;
  end

  always @(posedge clk_i or negedge arst_n_i) begin
    int          src;
    logic [71:0] exp;
    if (!arst_n_i) begin
      node_q = '0;
      en_q   = 1'b0;
      for (int p = 0; p < 3; p++) held_q[p] = '0;
    end else begin
      for (int p = 0; p < 3; p++) begin
        for (int o = 0; o < 5; o++) begin
          if (held_q[p][o] && (!ov[p][o] || od[p][o] !== held_d[p][o])) begin
            err_count++;
            $display("Fail %0t: plane %0d output %0d changed before it was accepted",
                     $time, p, o);
          end
          if (ov[p][o] && orr[p][o]) begin
            src = int'(hdr_field(p, od[p][o], 12));
            if (src > 4 || exp_q[p][src][o].size() == 0) begin
              err_count++;
              $display("Unexpected flit %h on plane %0d output %0d at %0t",
                       od[p][o], p, o, $time);
            end else begin
              exp = exp_q[p][src][o].pop_front();
              pending[p]--;
              checked++;
              if (exp !== od[p][o]) begin
                err_count++;
                $display("Fail %0t: plane %0d output %0d expected %h got %h",
                         $time, p, o, exp, od[p][o]);
              end
            end
          end
          held_q[p][o] = ov[p][o] && !orr[p][o];
          held_d[p][o] = od[p][o];
        end
        for (int i = 0; i < 5; i++) begin
          if (iv[p][i] && ir[p][i]) begin
            exp_q[p][i][expected_port(hdr_field(p, id[p][i], 6), node_q)].push_back(id[p][i]);
            pending[p]++;
          end
        end
        if (!en_q && ir[p] != '0) begin
          err_count++;
          $display("Fail %0t: plane %0d input ready high while disabled", $time, p);
        end
      end
      // Register writes happen as ack rises
      if (cfg_req_i && !cfg_ack_i) begin
        if (cfg_addr_i == noc_pkg::CfgAddrCoord) node_q = cfg_wdata_i[5:0];
        else en_q = cfg_wdata_i[0];
      end
    end
  end

endmodule

// File: dv/noc_nw_router_tb.sv
// Testbench top for the mesh router
// Clock, reset, configuration writes, directed and random traffic,
// back-pressure, plane stall and watchdog

`timescale 1ns/1ns

module noc_nw_router_tb;

  localparam int FlitCount = 930;
  localparam int TimeoutNs = (FlitCount * 40 + 200) * 4;

  logic                        clk;
  logic                        arst_n;
  logic                        cfg_req;
  noc_pkg::cfg_addr_t          cfg_addr;
  noc_pkg::cfg_data_t          cfg_wdata;
  logic                        cfg_ack;
  logic [4:0]                  in_vld [3];
  logic [71:0]                 in_dat [3][5];
  logic [4:0]                  in_rdy [3];
  logic [4:0]                  out_rdy [3];
  noc_pkg::narrow_flit_t [4:0] req_in_data;
  noc_pkg::narrow_flit_t [4:0] rsp_in_data;
  noc_pkg::narrow_flit_t [4:0] req_out_data;
  noc_pkg::narrow_flit_t [4:0] rsp_out_data;
  noc_pkg::wide_flit_t [4:0]   wide_in_data;
  noc_pkg::wide_flit_t [4:0]   wide_out_data;
  logic [4:0]                  req_out_valid;
  logic [4:0]                  rsp_out_valid;
  logic [4:0]                  wide_out_valid;
  int                          seed = 13517;
  int                          tb_errors = 0;
  int                          chk_errors;
  int                          checked;
  int                          pending [3];
  logic [2:0]                  cur_x;
  logic [2:0]                  cur_y;

  for (genvar g = 0; g < 5; g++) begin : gen_link
    assign req_in_data[g]  = in_dat[0][g][39:0];
    assign rsp_in_data[g]  = in_dat[1][g][39:0];
    assign wide_in_data[g] = in_dat[2][g];
  end

  noc_nw_router UUT (
    .clk_i (clk), .arst_n_i (arst_n),
    .cfg_req_i (cfg_req), .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
    .cfg_ack_o (cfg_ack),
    .req_in_valid_i (in_vld[0]), .req_in_ready_o (in_rdy[0]), .req_in_data_i (req_in_data),
    .req_out_valid_o (req_out_valid), .req_out_ready_i (out_rdy[0]),
    .req_out_data_o (req_out_data),
    .rsp_in_valid_i (in_vld[1]), .rsp_in_ready_o (in_rdy[1]), .rsp_in_data_i (rsp_in_data),
    .rsp_out_valid_o (rsp_out_valid), .rsp_out_ready_i (out_rdy[1]),
    .rsp_out_data_o (rsp_out_data),
    .wide_in_valid_i (in_vld[2]), .wide_in_ready_o (in_rdy[2]),
    .wide_in_data_i (wide_in_data),
    .wide_out_valid_o (wide_out_valid), .wide_out_ready_i (out_rdy[2]),
    .wide_out_data_o (wide_out_data)
  );

  noc_nw_router_checker u_checker (
    .clk_i (clk), .arst_n_i (arst_n),
    .cfg_req_i (cfg_req), .cfg_addr_i (cfg_addr), .cfg_wdata_i (cfg_wdata),
    .cfg_ack_i (cfg_ack),
    .req_in_valid_i (in_vld[0]), .req_in_ready_i (in_rdy[0]), .req_in_data_i (req_in_data),
    .req_out_valid_i (req_out_valid), .req_out_ready_i (out_rdy[0]),
    .req_out_data_i (req_out_data),
    .rsp_in_valid_i (in_vld[1]), .rsp_in_ready_i (in_rdy[1]), .rsp_in_data_i (rsp_in_data),
    .rsp_out_valid_i (rsp_out_valid), .rsp_out_ready_i (out_rdy[1]),
    .rsp_out_data_i (rsp_out_data),
    .wide_in_valid_i (in_vld[2]), .wide_in_ready_i (in_rdy[2]),
    .wide_in_data_i (wide_in_data),
    .wide_out_valid_i (wide_out_valid), .wide_out_ready_i (out_rdy[2]),
    .wide_out_data_i (wide_out_data),
    .err_count_o (chk_errors), .checked_o (checked), .pending_o (pending)
  );

  always #2 clk = ~clk;

  // Random payload with header {dst, src} at the flit top
  function automatic logic [71:0] make_flit(input int p, input logic [5:0] dst,
                                            input logic [5:0] src);
    logic [71:0] f;
    int          w;
    w = (p == 2) ? 72 : 40;
    f = 72'({$random(seed), $random(seed), $random(seed)});
    f[w-1 -: 12] = {dst, src};
    if (w < 72) f[71:40] = '0;
    return f;
  endfunction

  // Input i aims at Local, North, East, South, West of the node in turn
  function automatic logic [5:0] directed_dst(input int i);
    case (i)
      1:       return {cur_y + 3'd1, cur_x};
      2:       return {cur_y, cur_x + 3'd1};
      3:       return {cur_y - 3'd1, cur_x};
      4:       return {cur_y, cur_x - 3'd1};
      default: return {cur_y, cur_x};
    endcase
  endfunction

  task automatic cfg_write(input noc_pkg::cfg_addr_t addr, input noc_pkg::cfg_data_t data);
    int cycles;
    @(posedge clk);
    cfg_req   <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (!cfg_ack && cycles < 10);
    if (cycles != 2) begin
      tb_errors++;
      $display("Fail %0t: config ack rose after %0d cycles", $time, cycles);
    end
    cfg_req <= 1'b0;
    cycles = 0;
    do begin
      @(posedge clk);
      cycles++;
    end while (cfg_ack && cycles < 10);
    if (cycles != 2) begin
      tb_errors++;
      $display("Fail %0t: config ack fell after %0d cycles", $time, cycles);
    end
  endtask

  // Sends n flits per input; a stalled plane is released once the others drain
  task automatic run_traffic(input int n, input int stall_plane, input bit directed,
                             input bit rand_rdy);
    int rem [3][5];
    int stall;
    bit busy;
    bit others_done;
    stall = stall_plane;
    for (int p = 0; p < 3; p++) begin
      for (int i = 0; i < 5; i++) rem[p][i] = n;
    end
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      others_done = 1'b1;
      for (int p = 0; p < 3; p++) begin
        for (int i = 0; i < 5; i++) begin
          if (in_vld[p][i] && in_rdy[p][i]) rem[p][i]--;
          if (!in_vld[p][i] || in_rdy[p][i]) begin
            if (rem[p][i] > 0 && ($random(seed) & 1)) begin
              in_vld[p][i] <= 1'b1;
              in_dat[p][i] <= make_flit(p, directed ? directed_dst(i) : 6'($random(seed)),
                                        6'(i));
            end else begin
              in_vld[p][i] <= 1'b0;
            end
          end
          if (rem[p][i] > 0 || (in_vld[p][i] && !in_rdy[p][i])) busy = 1'b1;
          if (p != stall && (rem[p][i] > 0 || in_vld[p][i])) others_done = 1'b0;
        end
        if (p != stall && pending[p] != 0) others_done = 1'b0;
        out_rdy[p] <= (p == stall) ? 5'h00 : (rand_rdy ? 5'($random(seed)) : 5'h1f);
      end
      if (stall >= 0 && others_done) begin
        $display("Plane %0d released after the other planes drained at %0t", stall, $time);
        stall = -1;
      end
    end
  endtask

  task automatic drain();
    @(posedge clk);
    for (int p = 0; p < 3; p++) out_rdy[p] <= 5'h1f;
    while (pending[0] + pending[1] + pending[2] != 0) @(posedge clk);
    repeat (2) @(posedge clk);
  endtask

  initial begin
    clk       = 1'b0;
    arst_n    = 1'b0;
    cfg_req   = 1'b0;
    cfg_addr  = '0;
    cfg_wdata = '0;
    cur_x     = 3'd3;
    cur_y     = 3'd3;
    for (int p = 0; p < 3; p++) begin
      in_vld[p]  = '0;
      out_rdy[p] = '0;
      for (int i = 0; i < 5; i++) in_dat[p][i] = '0;
    end
    repeat (4) @(posedge clk);
    arst_n <= 1'b1;
    repeat (2) @(posedge clk);
    if (req_out_valid != '0 || rsp_out_valid != '0 || wide_out_valid != '0) begin
      tb_errors++;
      $display("Fail %0t: output valid high after reset", $time);
    end
    cfg_write(noc_pkg::CfgAddrCoord, {2'b00, cur_y, cur_x});
    cfg_write(noc_pkg::CfgAddrEnable, 8'h01);
    run_traffic(1, -1, 1'b1, 1'b0);
    drain();
    run_traffic(30, -1, 1'b0, 1'b1);
    drain();
    run_traffic(20, 2, 1'b0, 1'b1);
    drain();
    // New coordinate after the network is empty
    cur_x = 3'd5;
    cur_y = 3'd2;
    cfg_write(noc_pkg::CfgAddrCoord, {2'b00, cur_y, cur_x});
    run_traffic(1, -1, 1'b1, 1'b0);
    drain();
    run_traffic(10, -1, 1'b0, 1'b1);
    drain();
    $display("Flits checked %0d, checker errors %0d, testbench errors %0d",
             checked, chk_errors, tb_errors);
    if (chk_errors == 0 && tb_errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  initial begin
    #(TimeoutNs);
    $display("Timeout: run did not finish, %0d flits still in flight",
             pending[0] + pending[1] + pending[2]);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

// File: noc_nw_router.f
src/noc_pkg.sv
src/noc_input_fifo.sv
src/noc_xy_route.sv
src/noc_plane_router.sv
src/noc_route_cfg.sv
src/noc_nw_router.sv
dv/noc_nw_router_checker.sv
dv/noc_nw_router_tb.sv

// File: Makefile
# Verilator build and run for the mesh router testbench

VERILATOR ?= verilator
TOP       ?= noc_nw_router_tb
FILELIST  ?= noc_nw_router.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -Wno-fatal
PASS_STR  ?= RESULT: PASS

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx '$(PASS_STR)'

clean:
	rm -rf $(BUILD_DIR)
